//--- design/acc_cfg_pkg.sv
`default_nettype none

package acc_cfg_pkg;

  // one queue word is a full vector of lanes
  localparam int DATA_WIDTH = 512;
  localparam int LANE_WIDTH = 32;
  localparam int NUM_LANES  = 16;   // DATA_WIDTH / LANE_WIDTH

  // queue sizing
  localparam int QUEUE_DEPTH  = 8;
  localparam int QCOUNT_WIDTH = 4;  // holds 0..QUEUE_DEPTH

endpackage

`default_nettype wire

//--- design/acc_types_pkg.sv
`default_nettype none

package acc_types_pkg;

  typedef logic [acc_cfg_pkg::DATA_WIDTH-1:0] word_t;
  typedef logic [acc_cfg_pkg::LANE_WIDTH-1:0] lane_t;

  // occupancy, full depth included
  typedef logic [acc_cfg_pkg::QCOUNT_WIDTH-1:0] qcount_t;

  // kernel sequence: request operands, wait for them, write the sum
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    FETCH = 2'd1,
    WRITE = 2'd2
  } kernel_state_t;

endpackage

`default_nettype wire

//--- design/acc_in_queue.sv
`timescale 1ns/100ps
`default_nettype none

module acc_in_queue (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_en,
  input  acc_types_pkg::word_t wr_data,
  input  logic                 close,
  output logic                 full,
  output logic                 available,
  input  logic                 request_read,
  output logic                 read_data_valid,
  output acc_types_pkg::word_t read_data,
  output logic                 done_rd
);

  acc_types_pkg::word_t mem [acc_cfg_pkg::QUEUE_DEPTH];

  // depth is a power of two, pointers wrap on their own
  logic [acc_cfg_pkg::QCOUNT_WIDTH-2:0] wr_ptr;
  logic [acc_cfg_pkg::QCOUNT_WIDTH-2:0] rd_ptr;
  acc_types_pkg::qcount_t               count;
  logic                                 closed;
  logic                                 push;
  logic                                 pop;

  assign full      = (count == acc_types_pkg::qcount_t'(acc_cfg_pkg::QUEUE_DEPTH));
  assign available = (count != '0);
  assign push      = wr_en && !full;          // pushes into a full queue are dropped
  assign pop       = request_read && available;
  assign done_rd   = closed && !available;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr_data;
  end

  // output stage, data shows up the cycle after the request
  always_ff @(posedge clk) begin
    if (pop) read_data <= mem[rd_ptr];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      count           <= '0;
      read_data_valid <= 1'b0;
      closed          <= 1'b0;
    end else begin
      read_data_valid <= pop;
      if (close) closed <= 1'b1;  // sticky until reset
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_read_empty: assert property (
    @(posedge clk) disable iff (rst) request_read |-> available
  ) else $error("input queue read requested while empty");

  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> !full
  ) else $error("input queue pushed while full");

endmodule

`default_nettype wire

//--- design/acc_out_queue.sv
`timescale 1ns/100ps
`default_nettype none

module acc_out_queue (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 request_write,
  input  acc_types_pkg::word_t write_data,
  output logic                 available_write,
  input  logic                 rd_en,
  output acc_types_pkg::word_t rd_data,
  output logic                 empty,
  output logic                 done_wr
);

  acc_types_pkg::word_t mem [acc_cfg_pkg::QUEUE_DEPTH];

  logic [acc_cfg_pkg::QCOUNT_WIDTH-2:0] wr_ptr;
  logic [acc_cfg_pkg::QCOUNT_WIDTH-2:0] rd_ptr;
  acc_types_pkg::qcount_t               count;
  logic                                 push;
  logic                                 pop;

  assign available_write = (count != acc_types_pkg::qcount_t'(acc_cfg_pkg::QUEUE_DEPTH));
  assign empty           = (count == '0);
  assign done_wr         = empty;   // nothing left for the host
  assign push            = request_write && available_write;
  assign pop             = rd_en && !empty;

  // head word, popped at the edge where rd_en is seen
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= write_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the kernel checks room two cycles ahead of its write
  a_no_write_full: assert property (
    @(posedge clk) disable iff (rst) request_write |-> available_write
  ) else $error("result queue written while full");

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst) rd_en |-> !empty
  ) else $error("result queue popped while empty");

endmodule

`default_nettype wire

//--- design/acc_vec_add_kernel.sv
`timescale 1ns/100ps
`default_nettype none

module acc_vec_add_kernel (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 a_available,
  input  logic                 b_available,
  output logic                 a_request_read,
  output logic                 b_request_read,
  input  logic                 a_read_data_valid,
  input  logic                 b_read_data_valid,
  input  acc_types_pkg::word_t a_read_data,
  input  acc_types_pkg::word_t b_read_data,
  input  logic                 available_write,
  output logic                 request_write,
  output acc_types_pkg::word_t write_data,
  input  logic                 done_rd_a,
  input  logic                 done_rd_b,
  input  logic                 done_wr,
  output logic                 acc_done
);

  acc_types_pkg::kernel_state_t state;

  wire acc_types_pkg::word_t sum_word;
  logic                      pair_valid;
  logic                      idle;

  assign pair_valid = a_read_data_valid && b_read_data_valid;

  // no word in flight between the queues
  assign idle = (state == acc_types_pkg::IDLE) && !request_write;

  // lane adders, carries stay inside each lane
  for (genvar i = 0; i < acc_cfg_pkg::NUM_LANES; i++) begin : g_lane
    acc_types_pkg::lane_t a_lane;
    acc_types_pkg::lane_t b_lane;
    acc_types_pkg::lane_t lane_sum;

    assign a_lane = a_read_data[i*acc_cfg_pkg::LANE_WIDTH +: acc_cfg_pkg::LANE_WIDTH];
    assign b_lane = b_read_data[i*acc_cfg_pkg::LANE_WIDTH +: acc_cfg_pkg::LANE_WIDTH];

    always_ff @(posedge clk) begin
      if (pair_valid) lane_sum <= a_lane + b_lane;  // wraps mod 2^32
    end

    assign sum_word[i*acc_cfg_pkg::LANE_WIDTH +: acc_cfg_pkg::LANE_WIDTH] = lane_sum;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= acc_types_pkg::IDLE;
      a_request_read <= 1'b0;
      b_request_read <= 1'b0;
      request_write  <= 1'b0;
      write_data     <= '0;
      acc_done       <= 1'b0;
    end else begin
      // strobes last one cycle
      a_request_read <= 1'b0;
      b_request_read <= 1'b0;
      request_write  <= 1'b0;
      if (start) begin
        acc_done <= done_rd_a && done_rd_b && done_wr && idle;
        case (state)
          acc_types_pkg::IDLE: begin
            // room for the result is checked up front
            // a write issued last cycle is not counted in available_write yet
            if (!request_write && a_available && b_available && available_write) begin
              a_request_read <= 1'b1;
              b_request_read <= 1'b1;
              state          <= acc_types_pkg::FETCH;
            end
          end
          acc_types_pkg::FETCH: begin
            if (pair_valid) state <= acc_types_pkg::WRITE;  // sums land this edge
          end
          acc_types_pkg::WRITE: begin
            write_data    <= sum_word;
            request_write <= 1'b1;
            state         <= acc_types_pkg::IDLE;
          end
          default: state <= acc_types_pkg::IDLE;
        endcase
      end else if (state == acc_types_pkg::FETCH && pair_valid) begin
        // operands arrive once, keep them even when paused
        state <= acc_types_pkg::WRITE;
      end
    end
  end

  // both queues are popped together, so their data must line up
  a_valid_pair: assert property (
    @(posedge clk) disable iff (rst) a_read_data_valid == b_read_data_valid
  ) else $error("operand valid flags out of step");

endmodule

`default_nettype wire

//--- design/acc_top.sv
`timescale 1ns/100ps
`default_nettype none

module acc_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 a_wr_en,
  input  acc_types_pkg::word_t a_wr_data,
  input  logic                 b_wr_en,
  input  acc_types_pkg::word_t b_wr_data,
  input  logic                 in_last,
  input  logic                 res_rd_en,
  output logic                 a_full,
  output logic                 b_full,
  output acc_types_pkg::word_t res_rd_data,
  output logic                 res_empty,
  output logic                 acc_done
);

  // operand queue A
  logic                 a_available;
  logic                 a_request_read;
  logic                 a_read_data_valid;
  acc_types_pkg::word_t a_read_data;
  logic                 a_done_rd;

  // operand queue B
  logic                 b_available;
  logic                 b_request_read;
  logic                 b_read_data_valid;
  acc_types_pkg::word_t b_read_data;
  logic                 b_done_rd;

  // result queue
  logic                 available_write;
  logic                 request_write;
  acc_types_pkg::word_t write_data;
  logic                 done_wr;

  acc_in_queue u_a_queue (
    .clk             (clk),
    .rst             (rst),
    .wr_en           (a_wr_en),
    .wr_data         (a_wr_data),
    .close           (in_last),
    .full            (a_full),
    .available       (a_available),
    .request_read    (a_request_read),
    .read_data_valid (a_read_data_valid),
    .read_data       (a_read_data),
    .done_rd         (a_done_rd)
  );

  acc_in_queue u_b_queue (
    .clk             (clk),
    .rst             (rst),
    .wr_en           (b_wr_en),
    .wr_data         (b_wr_data),
    .close           (in_last),
    .full            (b_full),
    .available       (b_available),
    .request_read    (b_request_read),
    .read_data_valid (b_read_data_valid),
    .read_data       (b_read_data),
    .done_rd         (b_done_rd)
  );

  acc_vec_add_kernel u_kernel (
    .clk               (clk),
    .rst               (rst),
    .start             (start),
    .a_available       (a_available),
    .b_available       (b_available),
    .a_request_read    (a_request_read),
    .b_request_read    (b_request_read),
    .a_read_data_valid (a_read_data_valid),
    .b_read_data_valid (b_read_data_valid),
    .a_read_data       (a_read_data),
    .b_read_data       (b_read_data),
    .available_write   (available_write),
    .request_write     (request_write),
    .write_data        (write_data),
    .done_rd_a         (a_done_rd),
    .done_rd_b         (b_done_rd),
    .done_wr           (done_wr),
    .acc_done          (acc_done)
  );

  acc_out_queue u_res_queue (
    .clk             (clk),
    .rst             (rst),
    .request_write   (request_write),
    .write_data      (write_data),
    .available_write (available_write),
    .rd_en           (res_rd_en),
    .rd_data         (res_rd_data),
    .empty           (res_empty),
    .done_wr         (done_wr)
  );

endmodule

`default_nettype wire

//--- tests/acc_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module acc_clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

endmodule

`default_nettype wire

//--- tests/acc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module acc_tb;

  localparam int NUM_PAIRS  = 32;
  localparam int MAX_CYCLES = 20 * NUM_PAIRS + 500;
  localparam int WAIT_LIMIT = 100;  // cycles allowed for one result

  logic                 clk;
  logic                 rst;
  logic                 start;
  logic                 a_wr_en;
  acc_types_pkg::word_t a_wr_data;
  logic                 b_wr_en;
  acc_types_pkg::word_t b_wr_data;
  logic                 in_last;
  logic                 res_rd_en;
  logic                 a_full;
  logic                 b_full;
  acc_types_pkg::word_t res_rd_data;
  logic                 res_empty;
  logic                 acc_done;

  acc_types_pkg::word_t vectors [2*NUM_PAIRS];  // A at even index, B at odd
  acc_types_pkg::word_t expected [$];
  int                   errors = 0;
  int                   test_errors = 0;
  int                   tests_run = 0;
  int                   cycles = 0;
  int                   done_wait;
  logic                 inputs_closed = 1'b0;
  int unsigned          seed;

  acc_clk_gen u_clk_gen (.clk (clk));

  acc_top u_acc_top (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .a_wr_en     (a_wr_en),
    .a_wr_data   (a_wr_data),
    .b_wr_en     (b_wr_en),
    .b_wr_data   (b_wr_data),
    .in_last     (in_last),
    .res_rd_en   (res_rd_en),
    .a_full      (a_full),
    .b_full      (b_full),
    .res_rd_data (res_rd_data),
    .res_empty   (res_empty),
    .acc_done    (acc_done)
  );

  // each 32-bit lane wraps on its own
  function automatic acc_types_pkg::word_t lane_wise_sum(input acc_types_pkg::word_t a,
                                                        input acc_types_pkg::word_t b);
    acc_types_pkg::word_t sum;
    for (int i = 0; i < acc_cfg_pkg::NUM_LANES; i++) begin
      sum[i*32 +: 32] = a[i*32 +: 32] + b[i*32 +: 32];
    end
    return sum;
  endfunction

  task automatic compare_value(input string name, input acc_types_pkg::word_t actual,
                               input acc_types_pkg::word_t want);
    assert (actual === want) else begin
      $display("error: %0s expected %0h got %0h", name, want, actual);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %0s: %0d error(s)", name, test_errors);
    errors += test_errors;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic expect_pairs(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      expected.push_back(lane_wise_sum(vectors[2*i], vectors[2*i+1]));
    end
  endtask

  task automatic push_operands(input bit to_b, input int first, input int count,
                               input int max_gap);
    @(negedge clk);
    for (int i = first; i < first + count; i++) begin
      repeat ($urandom_range(max_gap, 0)) @(negedge clk);
      while (to_b ? b_full : a_full) @(negedge clk);  // hold the word until there is room
      if (to_b) begin
        b_wr_en   = 1'b1;
        b_wr_data = vectors[2*i+1];
      end else begin
        a_wr_en   = 1'b1;
        a_wr_data = vectors[2*i];
      end
      @(negedge clk);
      if (to_b) b_wr_en = 1'b0;
      else a_wr_en = 1'b0;
    end
  endtask

  task automatic pop_results(input int count, input int max_stall, input bit hold_for_full);
    int waited;
    @(negedge clk);
    if (hold_for_full) begin
      waited = 0;
      while (!a_full && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      assert (a_full) else begin
        $display("a_full never rose while pops were held back");
        test_errors++;
      end
      repeat (30) @(negedge clk);  // result queue fills too
    end
    for (int i = 0; i < count; i++) begin
      repeat ($urandom_range(max_stall, 0)) @(negedge clk);
      waited = 0;
      while (res_empty && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      assert (!res_empty) else begin
        $display("result %0d did not appear within %0d cycles", i, WAIT_LIMIT);
        test_errors++;
        return;
      end
      compare_value("res_rd_data", res_rd_data, expected.pop_front());
      res_rd_en = 1'b1;
      @(negedge clk);
      res_rd_en = 1'b0;
    end
  endtask

  task automatic run_stream(input int first, input int count, input int max_gap,
                            input int max_stall, input bit hold_for_full);
    expect_pairs(first, count);
    fork
      push_operands(1'b0, first, count, max_gap);
      push_operands(1'b1, first, count, max_gap);
      pop_results(count, max_stall, hold_for_full);
    join
    repeat (10) @(negedge clk);
    compare_value("res_empty", res_empty, 1'b1);  // no extra results
    expected.delete();
  endtask

  // acc_done has no business rising before in_last
  always @(negedge clk) begin
    if (!rst && !inputs_closed) compare_value("acc_done", acc_done, 1'b0);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    seed = 32'he099;
    void'($urandom(seed));
    rst       = 1'b1;
    start     = 1'b0;
    a_wr_en   = 1'b0;
    a_wr_data = '0;
    b_wr_en   = 1'b0;
    b_wr_data = '0;
    in_last   = 1'b0;
    res_rd_en = 1'b0;
    $readmemh("tests/acc_vectors.hex", vectors);
    assert (!$isunknown(vectors[2*NUM_PAIRS-1])) else begin
      $display("vector file tests/acc_vectors.hex is missing or too short");
      errors++;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    compare_value("res_empty", res_empty, 1'b1);
    compare_value("acc_done", acc_done, 1'b0);
    compare_value("a_full", a_full, 1'b0);
    compare_value("b_full", b_full, 1'b0);
    finish_test("reset");

    // operands sit in the queues until start
    expect_pairs(0, 3);
    fork
      push_operands(1'b0, 0, 3, 0);
      push_operands(1'b1, 0, 3, 0);
    join
    repeat (20) begin
      @(negedge clk);
      compare_value("res_empty", res_empty, 1'b1);
    end
    start = 1'b1;
    pop_results(3, 0, 1'b0);
    finish_test("start_gating");

    run_stream(3, 3, 0, 0, 1'b0);
    finish_test("lane_sums");
    run_stream(6, 8, 3, 3, 1'b0);
    finish_test("random_gaps");
    run_stream(14, 18, 0, 2, 1'b1);
    finish_test("back_pressure");

    // all results are drained, now close the inputs
    in_last       = 1'b1;
    inputs_closed = 1'b1;
    @(negedge clk);
    in_last   = 1'b0;
    done_wait = 0;
    while (!acc_done && done_wait < 20) begin
      @(negedge clk);
      done_wait++;
    end
    assert (acc_done) else begin
      $display("acc_done did not rise within 20 cycles of closing the inputs");
      test_errors++;
    end
    finish_test("done");

    $display("summary: %0d tests, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
design/acc_cfg_pkg.sv
design/acc_types_pkg.sv
design/acc_in_queue.sv
design/acc_out_queue.sv
design/acc_vec_add_kernel.sv
design/acc_top.sv
tests/acc_clk_gen.sv
tests/acc_tb.sv

//--- tests/acc_vectors.hex
// one operand pair per line: A word, then B word, 128 hex digits each
// lane 15 is the leftmost 8 digits of a word, lane 0 the rightmost
ffffffff00000001800000007fffffff123456789abcdef0deadbeef0badf00d00000000c0ffee0013579bdf2468ace031415926535897932718281828459045 00000001ffffffff7fffffff80000001fedcba9876543210a5a5a5a55a5a5a5acafef00dfeedface8badf00dd15ea5e0ffff00000000fffff0f0f0f00f0f0f0f
123456789abcdef0deadbeef0badf00dfedcba9876543210a5a5a5a55a5a5a5a00000001ffffffff7fffffff80000001cafef00dfeedface8badf00dd15ea5e0 ffff00000000fffff0f0f0f00f0f0f0f00000000c0ffee0013579bdf2468ace0ffffffff00000001800000007fffffff31415926535897932718281828459045
fedcba9876543210a5a5a5a55a5a5a5a00000000c0ffee0013579bdf2468ace0ffff00000000fffff0f0f0f00f0f0f0fffffffff00000001800000007fffffff 3141592653589793271828182845904500000001ffffffff7fffffff80000001123456789abcdef0deadbeef0badf00dcafef00dfeedface8badf00dd15ea5e0
00000000c0ffee0013579bdf2468ace000000001ffffffff7fffffff8000000131415926535897932718281828459045123456789abcdef0deadbeef0badf00d cafef00dfeedface8badf00dd15ea5e0ffff00000000fffff0f0f0f00f0f0f0ffedcba9876543210a5a5a5a55a5a5a5affffffff00000001800000007fffffff
00000001ffffffff7fffffff80000001ffff00000000fffff0f0f0f00f0f0f0fcafef00dfeedface8badf00dd15ea5e0fedcba9876543210a5a5a5a55a5a5a5a ffffffff00000001800000007fffffff3141592653589793271828182845904500000000c0ffee0013579bdf2468ace0123456789abcdef0deadbeef0badf00d
ffff00000000fffff0f0f0f00f0f0f0f31415926535897932718281828459045ffffffff00000001800000007fffffff00000000c0ffee0013579bdf2468ace0 123456789abcdef0deadbeef0badf00dcafef00dfeedface8badf00dd15ea5e000000001ffffffff7fffffff80000001fedcba9876543210a5a5a5a55a5a5a5a
31415926535897932718281828459045cafef00dfeedface8badf00dd15ea5e0123456789abcdef0deadbeef0badf00d00000001ffffffff7fffffff80000001 fedcba9876543210a5a5a5a55a5a5a5affffffff00000001800000007fffffffffff00000000fffff0f0f0f00f0f0f0f00000000c0ffee0013579bdf2468ace0
cafef00dfeedface8badf00dd15ea5e0ffffffff00000001800000007ffffffffedcba9876543210a5a5a5a55a5a5a5affff00000000fffff0f0f0f00f0f0f0f 00000000c0ffee0013579bdf2468ace0123456789abcdef0deadbeef0badf00d3141592653589793271828182845904500000001ffffffff7fffffff80000001
ffffffff00000001800000007ffffffffedcba9876543210a5a5a5a55a5a5a5a00000000c0ffee0013579bdf2468ace0cafef00dfeedface8badf00dd15ea5e0 ffff00000000fffff0f0f0f00f0f0f0ffedcba9876543210a5a5a5a55a5a5a5a123456789abcdef0deadbeef0badf00dffff00000000fffff0f0f0f00f0f0f0f
123456789abcdef0deadbeef0badf00d00000000c0ffee0013579bdf2468ace000000001ffffffff7fffffff80000001ffffffff00000001800000007fffffff 3141592653589793271828182845904500000000c0ffee0013579bdf2468ace0fedcba9876543210a5a5a5a55a5a5a5a31415926535897932718281828459045
fedcba9876543210a5a5a5a55a5a5a5a00000001ffffffff7fffffff80000001ffff00000000fffff0f0f0f00f0f0f0f123456789abcdef0deadbeef0badf00d cafef00dfeedface8badf00dd15ea5e000000001ffffffff7fffffff8000000100000000c0ffee0013579bdf2468ace0cafef00dfeedface8badf00dd15ea5e0
00000000c0ffee0013579bdf2468ace0ffff00000000fffff0f0f0f00f0f0f0f31415926535897932718281828459045fedcba9876543210a5a5a5a55a5a5a5a ffffffff00000001800000007fffffffffff00000000fffff0f0f0f00f0f0f0f00000001ffffffff7fffffff80000001ffffffff00000001800000007fffffff
00000001ffffffff7fffffff8000000131415926535897932718281828459045cafef00dfeedface8badf00dd15ea5e000000000c0ffee0013579bdf2468ace0 123456789abcdef0deadbeef0badf00d31415926535897932718281828459045ffff00000000fffff0f0f0f00f0f0f0f123456789abcdef0deadbeef0badf00d
ffff00000000fffff0f0f0f00f0f0f0fcafef00dfeedface8badf00dd15ea5e0ffffffff00000001800000007fffffff00000001ffffffff7fffffff80000001 fedcba9876543210a5a5a5a55a5a5a5acafef00dfeedface8badf00dd15ea5e031415926535897932718281828459045fedcba9876543210a5a5a5a55a5a5a5a
31415926535897932718281828459045ffffffff00000001800000007fffffff123456789abcdef0deadbeef0badf00dffff00000000fffff0f0f0f00f0f0f0f 00000000c0ffee0013579bdf2468ace0ffffffff00000001800000007fffffffcafef00dfeedface8badf00dd15ea5e000000000c0ffee0013579bdf2468ace0
cafef00dfeedface8badf00dd15ea5e0123456789abcdef0deadbeef0badf00dfedcba9876543210a5a5a5a55a5a5a5a31415926535897932718281828459045 00000001ffffffff7fffffff80000001123456789abcdef0deadbeef0badf00dffffffff00000001800000007fffffff00000001ffffffff7fffffff80000001
ffffffff00000001800000007fffffff00000000c0ffee0013579bdf2468ace000000000c0ffee0013579bdf2468ace0ffffffff00000001800000007fffffff 31415926535897932718281828459045fedcba9876543210a5a5a5a55a5a5a5a00000000c0ffee0013579bdf2468ace0ffff00000000fffff0f0f0f00f0f0f0f
123456789abcdef0deadbeef0badf00d00000001ffffffff7fffffff8000000100000001ffffffff7fffffff80000001123456789abcdef0deadbeef0badf00d cafef00dfeedface8badf00dd15ea5e000000000c0ffee0013579bdf2468ace000000001ffffffff7fffffff8000000131415926535897932718281828459045
fedcba9876543210a5a5a5a55a5a5a5affff00000000fffff0f0f0f00f0f0f0fffff00000000fffff0f0f0f00f0f0f0ffedcba9876543210a5a5a5a55a5a5a5a ffffffff00000001800000007fffffff00000001ffffffff7fffffff80000001ffff00000000fffff0f0f0f00f0f0f0fcafef00dfeedface8badf00dd15ea5e0
00000000c0ffee0013579bdf2468ace0314159265358979327182818284590453141592653589793271828182845904500000000c0ffee0013579bdf2468ace0 123456789abcdef0deadbeef0badf00dffff00000000fffff0f0f0f00f0f0f0f31415926535897932718281828459045ffffffff00000001800000007fffffff
00000001ffffffff7fffffff80000001cafef00dfeedface8badf00dd15ea5e0cafef00dfeedface8badf00dd15ea5e000000001ffffffff7fffffff80000001 fedcba9876543210a5a5a5a55a5a5a5a31415926535897932718281828459045cafef00dfeedface8badf00dd15ea5e0123456789abcdef0deadbeef0badf00d
ffff00000000fffff0f0f0f00f0f0f0fffffffff00000001800000007fffffffffffffff00000001800000007fffffffffff00000000fffff0f0f0f00f0f0f0f 00000000c0ffee0013579bdf2468ace0cafef00dfeedface8badf00dd15ea5e0ffffffff00000001800000007ffffffffedcba9876543210a5a5a5a55a5a5a5a
31415926535897932718281828459045123456789abcdef0deadbeef0badf00d123456789abcdef0deadbeef0badf00d31415926535897932718281828459045 00000001ffffffff7fffffff80000001ffffffff00000001800000007fffffff123456789abcdef0deadbeef0badf00d00000000c0ffee0013579bdf2468ace0
cafef00dfeedface8badf00dd15ea5e0fedcba9876543210a5a5a5a55a5a5a5afedcba9876543210a5a5a5a55a5a5a5acafef00dfeedface8badf00dd15ea5e0 ffff00000000fffff0f0f0f00f0f0f0f123456789abcdef0deadbeef0badf00dfedcba9876543210a5a5a5a55a5a5a5a00000001ffffffff7fffffff80000001
ffffffff00000001800000007fffffff00000001ffffffff7fffffff8000000100000000c0ffee0013579bdf2468ace0123456789abcdef0deadbeef0badf00d cafef00dfeedface8badf00dd15ea5e0fedcba9876543210a5a5a5a55a5a5a5affff00000000fffff0f0f0f00f0f0f0fffff00000000fffff0f0f0f00f0f0f0f
123456789abcdef0deadbeef0badf00dffff00000000fffff0f0f0f00f0f0f0f00000001ffffffff7fffffff80000001fedcba9876543210a5a5a5a55a5a5a5a ffffffff00000001800000007fffffff00000000c0ffee0013579bdf2468ace03141592653589793271828182845904531415926535897932718281828459045
fedcba9876543210a5a5a5a55a5a5a5a31415926535897932718281828459045ffff00000000fffff0f0f0f00f0f0f0f00000000c0ffee0013579bdf2468ace0 123456789abcdef0deadbeef0badf00d00000001ffffffff7fffffff80000001cafef00dfeedface8badf00dd15ea5e0cafef00dfeedface8badf00dd15ea5e0
00000000c0ffee0013579bdf2468ace0cafef00dfeedface8badf00dd15ea5e03141592653589793271828182845904500000001ffffffff7fffffff80000001 fedcba9876543210a5a5a5a55a5a5a5affff00000000fffff0f0f0f00f0f0f0fffffffff00000001800000007fffffffffffffff00000001800000007fffffff
00000001ffffffff7fffffff80000001ffffffff00000001800000007fffffffcafef00dfeedface8badf00dd15ea5e0ffff00000000fffff0f0f0f00f0f0f0f 00000000c0ffee0013579bdf2468ace031415926535897932718281828459045123456789abcdef0deadbeef0badf00d123456789abcdef0deadbeef0badf00d
ffff00000000fffff0f0f0f00f0f0f0f123456789abcdef0deadbeef0badf00dffffffff00000001800000007fffffff31415926535897932718281828459045 00000001ffffffff7fffffff80000001cafef00dfeedface8badf00dd15ea5e0fedcba9876543210a5a5a5a55a5a5a5afedcba9876543210a5a5a5a55a5a5a5a
31415926535897932718281828459045fedcba9876543210a5a5a5a55a5a5a5a123456789abcdef0deadbeef0badf00dcafef00dfeedface8badf00dd15ea5e0 ffff00000000fffff0f0f0f00f0f0f0fffffffff00000001800000007fffffff00000000c0ffee0013579bdf2468ace000000000c0ffee0013579bdf2468ace0
cafef00dfeedface8badf00dd15ea5e000000000c0ffee0013579bdf2468ace0fedcba9876543210a5a5a5a55a5a5a5affffffff00000001800000007fffffff 31415926535897932718281828459045123456789abcdef0deadbeef0badf00d00000001ffffffff7fffffff8000000100000001ffffffff7fffffff80000001
